/* rtl/core_config.svh */
//////////////////////////////////////////////////////////////////////
// Rename core sizing
// Data width, register file sizes and reorder buffer depth
//////////////////////////////////////////////////////////////////////

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data word width
`define XLEN 32

// Architectural registers, x0 included
`define ARCH_REGS 32

// Physical registers, free pool is the surplus over ARCH_REGS
`define PHYS_REGS 48

// Reorder buffer entries, power of two
`define ROB_DEPTH 8

`endif

/* rtl/isa_pkg.sv */
//////////////////////////////////////////////////////////////////////
// ISA definitions
// Instruction formats and the ALU subset that the core executes
//////////////////////////////////////////////////////////////////////

package isa_pkg;

    // Architectural register index
    typedef logic [4:0] arch_idx_t;

    // Major opcodes that are decoded
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_t;

    // Internal ALU operation
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // funct3 / funct7 encodings
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        arch_idx_t  rs2;
        arch_idx_t  rs1;
        logic [2:0] funct3;
        arch_idx_t  rd;
        opcode_t    opcode;
    } r_type_t;

    // Register-immediate format
    typedef struct packed {
        logic [11:0] imm;
        arch_idx_t   rs1;
        logic [2:0]  funct3;
        arch_idx_t   rd;
        opcode_t     opcode;
    } i_type_t;

    // Same 32-bit word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

endpackage

/* rtl/rename_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Rename datapath types
// Tags, indices and the packets passed between the rename blocks
//////////////////////////////////////////////////////////////////////

`include "core_config.svh"

package rename_pkg;
    import isa_pkg::*;

    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // Controller to map table
    typedef struct packed {
        arch_idx_t src1;
        arch_idx_t src2;
        arch_idx_t dest;
        logic      wr_en;
    } rename_req_t;

    // Map table lookups
    typedef struct packed {
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        phys_tag_t old_tag;
    } rename_rsp_t;

    // One ROB slot
    typedef struct packed {
        arch_idx_t dest;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
        logic      has_dest;
    } rob_entry_t;

    // Issue packet into the ALU
    typedef struct packed {
        alu_op_t          op;
        phys_tag_t        src1_tag;
        phys_tag_t        src2_tag;
        phys_tag_t        dest_tag;
        logic [`XLEN-1:0] imm;
        logic             use_imm;
        rob_idx_t         rob_idx;
    } issue_t;

    // Completion broadcast
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        phys_tag_t tag;
    } cdb_t;

    // In-order architectural commit
    typedef struct packed {
        logic             valid;
        arch_idx_t        idx;
        logic [`XLEN-1:0] data;
    } commit_t;

endpackage

/* rtl/map_table.sv */
//////////////////////////////////////////////////////////////////////
// Map table
// Architectural to physical tag mapping, read combinationally
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_config.svh"

module map_table import rename_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  rename_req_t map_req,
    input  logic        map_en,
    input  phys_tag_t   new_tag,
    output rename_rsp_t map_rsp
);

    // Current tag of each architectural register
    phys_tag_t map_q [`ARCH_REGS];

    // Lookups see the mapping from before this dispatch,
    // so a source equal to the destination gets the older producer
    assign map_rsp.src1_tag = map_q[map_req.src1];
    assign map_rsp.src2_tag = map_q[map_req.src2];
    // Previous producer, freed when this instruction retires
    assign map_rsp.old_tag  = map_q[map_req.dest];

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, x0 stays on tag 0 for good
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (map_en && map_req.wr_en) begin
            map_q[map_req.dest] <= new_tag;
        end
    end

endmodule

/* rtl/free_list.sv */
//////////////////////////////////////////////////////////////////////
// Free list
// Circular FIFO of unused physical tags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_config.svh"

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      pop,
    input  logic      push,
    input  phys_tag_t push_tag,
    output phys_tag_t head_tag,
    output logic      empty
);

    // Surplus of physical over architectural registers
    localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    phys_tag_t        fifo_q [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;

    // Next tag handed out at dispatch
    assign head_tag = fifo_q[head_q];
    assign empty    = (count_q == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // Starts full with the tags above the identity map
            for (int i = 0; i < DEPTH; i++) begin
                fifo_q[i] <= phys_tag_t'(`ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (PTR_W + 1)'(DEPTH);
        end else begin
            // Retire side
            if (push) begin
                fifo_q[tail_q] <= push_tag;
                tail_q         <= tail_q + 1'b1;
            end
            // Dispatch side
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            // Both in one cycle leaves the count unchanged
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* rtl/reorder_buffer.sv */
//////////////////////////////////////////////////////////////////////
// Reorder buffer
// Tracks completion from the CDB and retires in program order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_config.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             alloc,
    input  rob_entry_t       entry,
    input  cdb_t             cdb,
    input  logic [`XLEN-1:0] retire_data,
    output rob_idx_t         tail,
    output logic             full,
    output phys_tag_t        retire_tag,
    output logic             free_push,
    output phys_tag_t        free_tag,
    output commit_t          commit
);

    localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

    rob_entry_t            entries_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_q;
    rob_idx_t              head_q;
    rob_idx_t              tail_q;
    logic [CNT_W-1:0]      count_q;
    rob_entry_t            head_entry;
    logic                  retire;

    //////////////////////////////////////////////////////////////////////
    // Head and status
    //////////////////////////////////////////////////////////////////////

    assign head_entry = entries_q[head_q];
    // Oldest entry done, leaves this edge
    assign retire     = (count_q != '0) && done_q[head_q];

    assign tail = tail_q;
    assign full = (count_q == CNT_W'(`ROB_DEPTH));

    // PRF read port for the committed value
    assign retire_tag = head_entry.new_tag;

    // Superseded mapping goes back to the free list
    assign free_push = retire && head_entry.has_dest;
    assign free_tag  = head_entry.old_tag;

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            entries_q[tail_q] <= entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            commit  <= '0;
        end else begin
            if (alloc) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            // Completion two cycles after issue
            if (cdb.valid) begin
                done_q[cdb.rob_idx] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            if (alloc && !retire) begin
                count_q <= count_q + 1'b1;
            end else if (retire && !alloc) begin
                count_q <= count_q - 1'b1;
            end
            // No-destination entries report x0 with zero data
            commit.valid <= retire;
            commit.idx   <= head_entry.has_dest ? head_entry.dest : '0;
            commit.data  <= head_entry.has_dest ? retire_data : '0;
        end
    end

endmodule

/* rtl/dispatch_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Dispatch controller
// Req/ack handshake, decode, rename and ROB allocation, issue register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_config.svh"

module dispatch_ctrl import isa_pkg::*, rename_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        inst_req,
    input  inst_u       inst,
    input  rename_rsp_t map_rsp,
    input  logic        fl_empty,
    input  phys_tag_t   fl_tag,
    input  logic        rob_full,
    input  rob_idx_t    rob_tail,
    output logic        inst_ack,
    output rename_req_t map_req,
    output logic        fl_pop,
    output logic        rob_alloc,
    output rob_entry_t  rob_entry,
    output issue_t      issue,
    output logic        issue_valid
);

    typedef enum logic {
        S_IDLE,
        S_ACK
    } state_t;

    state_t           state_q;
    logic             accept;
    logic             use_imm;
    logic             has_dest;
    alu_op_t          alu_op;
    logic [`XLEN-1:0] imm_ext;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign use_imm  = (inst.i.opcode == OPC_OP_IMM);
    // Writes to x0 are dropped, no rename needed
    assign has_dest = (inst.r.rd != '0);
    assign imm_ext  = {{(`XLEN - 12){inst.i.imm[11]}}, inst.i.imm};

    always_comb begin
        case (inst.r.funct3)
            // funct7 only exists in the R-type view
            F3_ADD:  alu_op = (!use_imm && inst.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            F3_XOR:  alu_op = ALU_XOR;
            F3_OR:   alu_op = ALU_OR;
            F3_AND:  alu_op = ALU_AND;
            default: alu_op = ALU_ADD;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Rename and allocate
    //////////////////////////////////////////////////////////////////////

    // Take a new instruction only with a free tag and a free ROB slot
    assign accept   = (state_q == S_IDLE) && inst_req && !fl_empty && !rob_full;
    assign inst_ack = (state_q == S_ACK);

    assign map_req.src1  = inst.r.rs1;
    assign map_req.src2  = use_imm ? arch_idx_t'(0) : inst.r.rs2;
    assign map_req.dest  = inst.r.rd;
    assign map_req.wr_en = has_dest;

    assign fl_pop    = accept && has_dest;
    assign rob_alloc = accept;

    assign rob_entry.dest     = inst.r.rd;
    assign rob_entry.new_tag  = has_dest ? fl_tag : '0;
    assign rob_entry.old_tag  = map_rsp.old_tag;
    assign rob_entry.has_dest = has_dest;

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM and issue register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q     <= S_IDLE;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
            case (state_q)
                S_IDLE:  if (accept) state_q <= S_ACK;
                // Hold ack until the requester lets go
                S_ACK:   if (!inst_req) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            issue.op       <= alu_op;
            issue.src1_tag <= map_rsp.src1_tag;
            issue.src2_tag <= map_rsp.src2_tag;
            // Tag 0 for x0, the ALU drops that write
            issue.dest_tag <= rob_entry.new_tag;
            issue.imm      <= imm_ext;
            issue.use_imm  <= use_imm;
            issue.rob_idx  <= rob_tail;
        end
    end

endmodule

/* rtl/alu_exec.sv */
//////////////////////////////////////////////////////////////////////
// Execute stage
// Physical register file, two-stage ALU and the CDB broadcast
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_config.svh"

module alu_exec import isa_pkg::*, rename_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  issue_t           issue,
    input  logic             issue_valid,
    input  phys_tag_t        read_tag,
    output cdb_t             cdb,
    output logic [`XLEN-1:0] read_data
);

    logic [`XLEN-1:0] prf_q [`PHYS_REGS];
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result_q;
    cdb_t             done_q;

    //////////////////////////////////////////////////////////////////////
    // Stage 1, operand read and compute
    //////////////////////////////////////////////////////////////////////

    // In-order issue, the producer has always written back by now
    assign op_a = prf_q[issue.src1_tag];
    assign op_b = issue.use_imm ? issue.imm : prf_q[issue.src2_tag];

    always_comb begin
        case (issue.op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        result_q <= alu_out;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q <= '0;
        end else begin
            done_q.valid   <= issue_valid;
            done_q.rob_idx <= issue.rob_idx;
            done_q.tag     <= issue.dest_tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2, writeback and broadcast
    //////////////////////////////////////////////////////////////////////

    assign cdb = done_q;

    // Retire read port
    assign read_data = prf_q[read_tag];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                prf_q[i] <= '0;
            end
        end else if (done_q.valid && done_q.tag != '0) begin
            // Tag 0 is never written and stays zero
            prf_q[done_q.tag] <= result_q;
        end
    end

endmodule

/* rtl/rename_core.sv */
//////////////////////////////////////////////////////////////////////
// Rename core top
// Dispatch, rename, ROB and execute blocks wired together
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_config.svh"

module rename_core import isa_pkg::*, rename_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    inst_req,
    input  inst_u   inst,
    output logic    inst_ack,
    output commit_t commit
);

    // Rename
    rename_req_t map_req;
    rename_rsp_t map_rsp;
    logic        fl_pop;
    logic        fl_empty;
    phys_tag_t   fl_tag;

    // Reorder buffer
    logic        rob_alloc;
    rob_entry_t  rob_entry;
    logic        rob_full;
    rob_idx_t    rob_tail;
    logic        free_push;
    phys_tag_t   free_tag;
    phys_tag_t   retire_tag;

    // Execute
    issue_t           issue;
    logic             issue_valid;
    cdb_t             cdb;
    logic [`XLEN-1:0] retire_data;

    dispatch_ctrl u_dispatch (
        .clock       (clock),
        .reset       (reset),
        .inst_req    (inst_req),
        .inst        (inst),
        .map_rsp     (map_rsp),
        .fl_empty    (fl_empty),
        .fl_tag      (fl_tag),
        .rob_full    (rob_full),
        .rob_tail    (rob_tail),
        .inst_ack    (inst_ack),
        .map_req     (map_req),
        .fl_pop      (fl_pop),
        .rob_alloc   (rob_alloc),
        .rob_entry   (rob_entry),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    // Mapping updates on every accepted dispatch
    map_table u_map_table (
        .clock   (clock),
        .reset   (reset),
        .map_req (map_req),
        .map_en  (rob_alloc),
        .new_tag (fl_tag),
        .map_rsp (map_rsp)
    );

    free_list u_free_list (
        .clock    (clock),
        .reset    (reset),
        .pop      (fl_pop),
        .push     (free_push),
        .push_tag (free_tag),
        .head_tag (fl_tag),
        .empty    (fl_empty)
    );

    reorder_buffer u_rob (
        .clock       (clock),
        .reset       (reset),
        .alloc       (rob_alloc),
        .entry       (rob_entry),
        .cdb         (cdb),
        .retire_data (retire_data),
        .tail        (rob_tail),
        .full        (rob_full),
        .retire_tag  (retire_tag),
        .free_push   (free_push),
        .free_tag    (free_tag),
        .commit      (commit)
    );

    alu_exec u_alu_exec (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .issue_valid (issue_valid),
        .read_tag    (retire_tag),
        .cdb         (cdb),
        .read_data   (retire_data)
    );

endmodule

/* tests/tb_rename_core.sv */
//////////////////////////////////////////////////////////////////////
// Rename core testbench
// Directed and random ALU streams checked against a register model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_config.svh"

module tb_rename_core import isa_pkg::*, rename_pkg::*; ();

    // Operation kinds used by the stimulus
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_ADDI = 5;
    // Cycles allowed for any single wait
    localparam int TIMEOUT = 200;

    logic             clock;
    logic             reset;
    logic             inst_req;
    inst_u            inst;
    logic             inst_ack;
    commit_t          commit;
    logic [`XLEN-1:0] model_rf [`ARCH_REGS];
    commit_t          exp_q [$];
    logic [15:0]      lfsr_q;
    int               n;

    rename_core UUT (
        .clock    (clock),
        .reset    (reset),
        .inst_req (inst_req),
        .inst     (inst),
        .inst_ack (inst_ack),
        .commit   (commit)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL at %0t ns: commit v=%b x%0d=%h, expected v=%b x%0d=%h",
                               $time, got.valid, got.idx, got.data,
                               exp.valid, exp.idx, exp.data));
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL at %0t ns: inst_ack=%b, expected %b (%s)",
                               $time, got, exp, what));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    //////////////////////////////////////////////////////////////////////

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < width; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic inst_u make_inst(input int kind, input arch_idx_t rd,
                                        input arch_idx_t rs1, input arch_idx_t rs2,
                                        input logic [11:0] imm);
        inst_u u;
        u.r.funct7 = (kind == K_SUB) ? F7_SUB : 7'b0;
        u.r.rs2    = rs2;
        u.r.rs1    = rs1;
        u.r.rd     = rd;
        u.r.opcode = OPC_OP;
        case (kind)
            K_AND:   u.r.funct3 = F3_AND;
            K_OR:    u.r.funct3 = F3_OR;
            K_XOR:   u.r.funct3 = F3_XOR;
            default: u.r.funct3 = F3_ADD;
        endcase
        // I-type reuses rd, rs1 and funct3 positions
        if (kind == K_ADDI) begin
            u.i.imm    = imm;
            u.i.opcode = OPC_OP_IMM;
        end
        return u;
    endfunction

    function automatic logic [`XLEN-1:0] ref_alu(input int kind, input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (kind)
            K_SUB:   return a - b;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            default: return a + b;
        endcase
    endfunction

    // Full four-phase transfer, entered and left 1 ns after an edge
    task automatic send_inst(input int kind, input arch_idx_t rd, input arch_idx_t rs1,
                             input arch_idx_t rs2, input logic [11:0] imm);
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] result;
        commit_t          exp;
        int               t;
        inst     = make_inst(kind, rd, rs1, rs2, imm);
        inst_req = 1'b1;
        t = 0;
        do begin
            @(posedge clock);
            #1;
            t++;
            if (t > TIMEOUT) fail_run("Timeout: request was never acknowledged");
        end while (inst_ack !== 1'b1);
        // Accepted, so model it in dispatch order
        b      = (kind == K_ADDI) ? {{(`XLEN - 12){imm[11]}}, imm} : model_rf[rs2];
        result = ref_alu(kind, model_rf[rs1], b);
        exp.valid = 1'b1;
        exp.idx   = rd;
        exp.data  = (rd == '0) ? '0 : result;
        if (rd != '0) model_rf[rd] = result;
        exp_q.push_back(exp);
        // Ack holds while req stays up
        @(posedge clock);
        #1;
        check_ack(inst_ack, 1'b1, "held while req high");
        inst_req = 1'b0;
        t = 0;
        do begin
            @(posedge clock);
            #1;
            t++;
            if (t > TIMEOUT) fail_run("Timeout: ack stayed high after req dropped");
        end while (inst_ack !== 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Commit monitor
    //////////////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(posedge clock);
            #1;
            if (commit.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    fail_run($sformatf("FAIL at %0t ns: commit with nothing pending", $time));
                end else begin
                    check_commit(commit, exp_q.pop_front());
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset    = 1'b1;
        inst_req = 1'b0;
        inst     = '0;
        lfsr_q   = 16'd44;
        for (int i = 0; i < `ARCH_REGS; i++) model_rf[i] = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        // Idle after reset
        for (int i = 0; i < 6; i++) begin
            @(posedge clock);
            #1;
            check_ack(inst_ack, 1'b0, "idle after reset");
            check_commit(commit, '0);
        end

        // Every operation, negative immediates, x0 as source
        send_inst(K_ADDI, 5'd1, 5'd0, 5'd0, 12'd100);
        send_inst(K_ADDI, 5'd2, 5'd0, 5'd0, -12'sd7);
        send_inst(K_ADD,  5'd3, 5'd1, 5'd2, 12'd0);
        send_inst(K_SUB,  5'd4, 5'd1, 5'd2, 12'd0);
        send_inst(K_AND,  5'd5, 5'd1, 5'd2, 12'd0);
        send_inst(K_OR,   5'd6, 5'd1, 5'd2, 12'd0);
        send_inst(K_XOR,  5'd7, 5'd1, 5'd2, 12'd0);
        send_inst(K_ADDI, 5'd8, 5'd1, 5'd0, -12'sd300);
        send_inst(K_ADD,  5'd9, 5'd0, 5'd1, 12'd0);

        // Destination x0 is dropped
        send_inst(K_ADD,  5'd0, 5'd1, 5'd2, 12'd0);
        send_inst(K_ADD,  5'd10, 5'd0, 5'd0, 12'd0);

        // Dependent chain through one register
        for (int i = 0; i < 12; i++) begin
            send_inst(K_ADDI, 5'd11, 5'd11, 5'd0, 12'(i * 3 + 1));
        end
        send_inst(K_SUB, 5'd11, 5'd11, 5'd4, 12'd0);
        send_inst(K_XOR, 5'd12, 5'd11, 5'd11, 12'd0);

        // Random stream over x0..x3
        for (int i = 0; i < 200; i++) begin
            send_inst(int'(rand_bits(3)) % 6, arch_idx_t'(rand_bits(2)),
                      arch_idx_t'(rand_bits(2)), arch_idx_t'(rand_bits(2)),
                      12'(rand_bits(12)));
        end

        // Drain outstanding commits
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            fail_run($sformatf("Timeout: %0d commits never arrived", exp_q.size()));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* build.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/dispatch_ctrl.sv
rtl/alu_exec.sv
rtl/rename_core.sv
tests/tb_rename_core.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/rename_pkg.sv
      - rtl/map_table.sv
      - rtl/free_list.sv
      - rtl/reorder_buffer.sv
      - rtl/dispatch_ctrl.sv
      - rtl/alu_exec.sv
      - rtl/rename_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_rename_core.sv
